// File: hdl/core_cfg_pkg.sv
package core_cfg_pkg;

   localparam int CNT_W = 5;

   localparam logic [31:0] RESET_PC = 32'h0000_0000;

   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      EXEC,
      MEM,
      LOAD_WB
   } state_e;

   // Source of the rd write bit
   localparam logic [1:0] RD_ALU  = 2'd0;
   localparam logic [1:0] RD_LINK = 2'd1;
   localparam logic [1:0] RD_MEM  = 2'd2;

endpackage

// File: hdl/core_state.sv
module core_state import core_cfg_pkg::*; (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_ibus_ack,
   input  logic             i_dbus_ack,
   input  logic             i_mem_op,
   input  logic             i_is_load,
   output logic             o_ibus_cyc,
   output logic             o_dbus_cyc,
   output logic [CNT_W-1:0] o_cnt,
   output logic             o_cnt_en,
   output logic             o_cnt_done,
   output logic             o_exec,
   output logic             o_load_wb,
   output logic             o_pc_en
);

   state_e state;

   // Bus requests follow the state register directly
   assign o_ibus_cyc = (state == FETCH);
   assign o_dbus_cyc = (state == MEM);
   assign o_exec     = (state == EXEC);
   assign o_load_wb  = (state == LOAD_WB);
   assign o_cnt_en   = o_exec | o_load_wb;
   assign o_cnt_done = o_cnt_en & (o_cnt == '1);

   // End of instruction
   assign o_pc_en = (o_exec & o_cnt_done & !i_mem_op) |
                    (o_dbus_cyc & i_dbus_ack & !i_is_load) |
                    (o_load_wb & o_cnt_done);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= IDLE;
         o_cnt <= '0;
      end else begin
         // Wraps back to zero after each 32-bit phase
         if (o_cnt_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         case (state)
            IDLE: begin
               state <= FETCH;
            end
            FETCH: begin
               if (i_ibus_ack) begin
                  state <= EXEC;
               end
            end
            EXEC: begin
               if (o_cnt_done) begin
                  state <= i_mem_op ? MEM : FETCH;
               end
            end
            MEM: begin
               if (i_dbus_ack) begin
                  state <= i_is_load ? LOAD_WB : FETCH;
               end
            end
            LOAD_WB: begin
               if (o_cnt_done) begin
                  state <= FETCH;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

// File: hdl/instr_decode.sv
module instr_decode import rv_isa_pkg::*; import core_cfg_pkg::*; (
   input  logic              clk,
   input  logic              i_ibus_ack,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   input  logic              i_cnt_en,
   output alu_op_e           o_alu_op,
   output logic              o_op_b_imm,
   output logic [1:0]        o_rd_src,
   output logic              o_rd_wen,
   output logic [REG_AW-1:0] o_rs1_adr,
   output logic [REG_AW-1:0] o_rs2_adr,
   output logic [REG_AW-1:0] o_rd_adr,
   output logic              o_mem_op,
   output logic              o_is_load,
   output logic              o_is_store,
   output logic              o_branch,
   output logic              o_branch_ne,
   output logic              o_jal,
   output logic              o_imm_bit
);

   logic [XLEN-1:0] ir;
   logic [XLEN-1:0] imm_q;
   logic [XLEN-1:0] imm_new;
   logic [XLEN-1:0] r;
   logic [2:0]      f3;
   logic            f3_ok;
   alu_op_e         alu_f3;
   imm_fmt_e        fmt;
   opcode_e         opc;
   opcode_e         raw_opc;

   assign r       = i_ibus_rdt;
   assign raw_opc = opcode_e'(r[OPC_W-1:0]);
   assign opc     = opcode_e'(ir[OPC_W-1:0]);
   assign f3      = ir[F3_LSB +: 3];

   assign o_rs1_adr = ir[RS1_LSB +: REG_AW];
   assign o_rs2_adr = ir[RS2_LSB +: REG_AW];
   assign o_rd_adr  = ir[RD_LSB +: REG_AW];
   assign o_imm_bit = imm_q[0];

   // Immediate format has to come from the word on the bus
   always_comb begin
      case (raw_opc)
         OPC_LUI:    fmt = IMM_U;
         OPC_STORE:  fmt = IMM_S;
         OPC_BRANCH: fmt = IMM_B;
         OPC_JAL:    fmt = IMM_J;
         default:    fmt = IMM_I;
      endcase
      case (fmt)
         IMM_S:   imm_new = {{20{r[31]}}, r[31:25], r[11:7]};
         IMM_B:   imm_new = {{19{r[31]}}, r[31], r[7], r[30:25], r[11:8], 1'b0};
         IMM_U:   imm_new = {r[31:12], 12'b0};
         IMM_J:   imm_new = {{11{r[31]}}, r[31], r[19:12], r[20], r[30:21], 1'b0};
         default: imm_new = {{20{r[31]}}, r[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ir    <= i_ibus_rdt;
         imm_q <= imm_new;
      end else if (i_cnt_en) begin
         // Sign bit keeps filling from the top
         imm_q <= {imm_q[XLEN-1], imm_q[XLEN-1:1]};
      end
   end

   always_comb begin
      case (f3)
         FUNCT3_XOR: alu_f3 = ALU_XOR;
         FUNCT3_OR:  alu_f3 = ALU_OR;
         FUNCT3_AND: alu_f3 = ALU_AND;
         default:    alu_f3 = ALU_ADD;
      endcase
      f3_ok = (f3 == FUNCT3_ADD) || (f3 == FUNCT3_XOR) || (f3 == FUNCT3_OR) ||
              (f3 == FUNCT3_AND);
   end

   always_comb begin
      o_alu_op    = ALU_ADD;
      o_op_b_imm  = 1'b0;
      o_rd_src    = RD_ALU;
      o_rd_wen    = 1'b0;
      o_mem_op    = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_branch    = 1'b0;
      o_branch_ne = (f3 == FUNCT3_BNE);
      o_jal       = 1'b0;
      case (opc)
         OPC_LUI: begin
            o_alu_op   = ALU_PASS_B;
            o_op_b_imm = 1'b1;
            o_rd_wen   = 1'b1;
         end
         OPC_OP_IMM: begin
            o_alu_op   = alu_f3;
            o_op_b_imm = 1'b1;
            o_rd_wen   = f3_ok;
         end
         OPC_OP: begin
            o_alu_op = (f3 == FUNCT3_ADD && ir[F7_SUB_BIT]) ? ALU_SUB : alu_f3;
            o_rd_wen = f3_ok;
         end
         OPC_LOAD: begin
            o_op_b_imm = 1'b1;
            o_mem_op   = 1'b1;
            o_is_load  = 1'b1;
            o_rd_src   = RD_MEM;
            o_rd_wen   = 1'b1;
         end
         OPC_STORE: begin
            o_op_b_imm = 1'b1;
            o_mem_op   = 1'b1;
            o_is_store = 1'b1;
         end
         OPC_BRANCH: begin
            o_branch = (f3 == FUNCT3_BEQ) || (f3 == FUNCT3_BNE);
         end
         OPC_JAL: begin
            o_jal    = 1'b1;
            o_rd_src = RD_LINK;
            o_rd_wen = 1'b1;
         end
         default: begin
            o_rd_wen = 1'b0;
         end
      endcase
   end

endmodule

// File: hdl/mem_bufreg.sv
module mem_bufreg import rv_isa_pkg::*; (
   input  logic            clk,
   input  logic            i_cnt_en,
   input  logic            i_exec,
   input  logic            i_sum_bit,
   input  logic            i_rs2_bit,
   input  logic            i_dbus_ack,
   input  logic [XLEN-1:0] i_dbus_rdt,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_load_bit
);

   logic [XLEN-1:0] dat_q;

   assign o_dbus_dat = dat_q;
   assign o_load_bit = dat_q[0];

   always_ff @(posedge clk) begin
      // Address bits arrive LSB first from the ALU sum
      if (i_cnt_en && i_exec) begin
         o_dbus_adr <= {i_sum_bit, o_dbus_adr[XLEN-1:1]};
      end
   end

   // Store data and load data share one register
   always_ff @(posedge clk) begin
      if (i_cnt_en && i_exec) begin
         dat_q <= {i_rs2_bit, dat_q[XLEN-1:1]};
      end else if (i_dbus_ack) begin
         dat_q <= i_dbus_rdt;
      end else if (i_cnt_en) begin
         // LOAD_WB, one bit out per cycle
         dat_q <= {1'b0, dat_q[XLEN-1:1]};
      end
   end

endmodule

// File: hdl/pc_ctrl.sv
module pc_ctrl import rv_isa_pkg::*; import core_cfg_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_cnt_en,
   input  logic            i_first,
   input  logic            i_pc_en,
   input  logic            i_imm_bit,
   input  logic            i_take_target,
   output logic [XLEN-1:0] o_pc,
   output logic            o_link_bit
);

   logic [XLEN-1:0] plus4_q;
   logic [XLEN-1:0] tgt_q;
   logic [XLEN-1:0] plus4_nxt;
   logic [XLEN-1:0] tgt_nxt;
   logic [XLEN-1:0] new_pc;
   logic [1:0]      lead;
   logic            c4;
   logic            ct;
   logic            c4_q;
   logic            ct_q;
   logic            bit2;
   logic            tgt_bit;

   // lead[1] marks bit 2, where the constant 4 has its only one
   assign bit2       = lead[1];
   assign c4         = !i_first & c4_q;
   assign ct         = !i_first & ct_q;
   assign o_link_bit = o_pc[0] ^ bit2 ^ c4;
   assign tgt_bit    = o_pc[0] ^ i_imm_bit ^ ct;
   assign plus4_nxt  = {o_link_bit, plus4_q[XLEN-1:1]};
   assign tgt_nxt    = {tgt_bit, tgt_q[XLEN-1:1]};

   // At the last EXEC bit the final sum bit is still on its way in
   always_comb begin
      if (i_take_target) begin
         new_pc = i_cnt_en ? tgt_nxt : tgt_q;
      end else begin
         new_pc = i_cnt_en ? plus4_nxt : plus4_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         c4_q    <= (o_pc[0] & bit2) | (c4 & (o_pc[0] ^ bit2));
         ct_q    <= (o_pc[0] & i_imm_bit) | (ct & (o_pc[0] ^ i_imm_bit));
         plus4_q <= plus4_nxt;
         tgt_q   <= tgt_nxt;
      end
      if (i_rst) begin
         lead <= '0;
         o_pc <= RESET_PC;
      end else begin
         if (i_cnt_en) begin
            lead <= {lead[0], i_first};
         end
         // Rotated once round during EXEC, so it is intact afterwards
         if (i_pc_en) begin
            o_pc <= new_pc;
         end else if (i_cnt_en) begin
            o_pc <= {o_pc[0], o_pc[XLEN-1:1]};
         end
      end
   end

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int NREGS  = 2 ** REG_AW;

   // Instruction field positions
   localparam int OPC_W      = 7;
   localparam int RD_LSB     = 7;
   localparam int F3_LSB     = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int F7_SUB_BIT = 30;

   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [2:0] {
      IMM_I,
      IMM_S,
      IMM_B,
      IMM_U,
      IMM_J
   } imm_fmt_e;

   localparam logic [2:0] FUNCT3_ADD = 3'b000;
   localparam logic [2:0] FUNCT3_XOR = 3'b100;
   localparam logic [2:0] FUNCT3_OR  = 3'b110;
   localparam logic [2:0] FUNCT3_AND = 3'b111;
   localparam logic [2:0] FUNCT3_BEQ = 3'b000;
   localparam logic [2:0] FUNCT3_BNE = 3'b001;

endpackage

// File: hdl/serial_alu.sv
module serial_alu import rv_isa_pkg::*; (
   input  logic    clk,
   input  logic    i_cnt_en,
   input  logic    i_first,
   input  alu_op_e i_op,
   input  logic    i_rs1_bit,
   input  logic    i_op_b_bit,
   output logic    o_rd_bit,
   output logic    o_eq
);

   logic is_sub;
   logic b;
   logic cin;
   logic sum;
   logic carry_q;
   logic eq_q;

   // Subtract is rs1 + ~b + 1
   assign is_sub = (i_op == ALU_SUB);
   assign b      = i_op_b_bit ^ is_sub;
   assign cin    = i_first ? is_sub : carry_q;
   assign sum    = i_rs1_bit ^ b ^ cin;

   // Includes the current bit, so it is complete during bit 31
   assign o_eq = (i_first | eq_q) & !(i_rs1_bit ^ i_op_b_bit);

   always_comb begin
      case (i_op)
         ALU_AND:    o_rd_bit = i_rs1_bit & i_op_b_bit;
         ALU_OR:     o_rd_bit = i_rs1_bit | i_op_b_bit;
         ALU_XOR:    o_rd_bit = i_rs1_bit ^ i_op_b_bit;
         ALU_PASS_B: o_rd_bit = i_op_b_bit;
         default:    o_rd_bit = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1_bit & b) | (cin & (i_rs1_bit ^ b));
         eq_q    <= o_eq;
      end
   end

endmodule

// File: hdl/serial_core_top.sv
module serial_core_top import rv_isa_pkg::*; import core_cfg_pkg::*; (
   input  logic            clk,
   input  logic            i_rst,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   input  logic [XLEN-1:0] i_dbus_rdt,
   input  logic            i_dbus_ack,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc
);

   logic [CNT_W-1:0]  cnt;
   logic              cnt_en;
   logic              exec;
   logic              load_wb;
   logic              pc_en;
   logic              first;
   alu_op_e           alu_op;
   logic              op_b_imm;
   logic [1:0]        rd_src;
   logic              rd_wen;
   logic [REG_AW-1:0] rs1_adr;
   logic [REG_AW-1:0] rs2_adr;
   logic [REG_AW-1:0] rd_adr;
   logic              mem_op;
   logic              is_load;
   logic              is_store;
   logic              branch;
   logic              branch_ne;
   logic              jal;
   logic              imm_bit;
   logic              rs1_bit;
   logic              rs2_bit;
   logic              op_b_bit;
   logic              alu_bit;
   logic              alu_eq;
   logic              link_bit;
   logic              load_bit;
   logic              rd_bit;
   logic              rf_wen;
   logic              take_target;

   assign first       = cnt_en & (cnt == '0);
   assign op_b_bit    = op_b_imm ? imm_bit : rs2_bit;
   assign take_target = jal | (branch & (alu_eq ^ branch_ne));
   assign o_dbus_we   = is_store;

   // Loads write rd only in LOAD_WB, everything else during EXEC
   assign rf_wen = rd_wen & (is_load ? load_wb : exec);

   always_comb begin
      case (rd_src)
         RD_LINK: rd_bit = link_bit;
         RD_MEM:  rd_bit = load_bit;
         default: rd_bit = alu_bit;
      endcase
   end

   core_state state (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_mem_op   (mem_op),
      .i_is_load  (is_load),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (),
      .o_exec     (exec),
      .o_load_wb  (load_wb),
      .o_pc_en    (pc_en)
   );

   instr_decode decode (
      .clk         (clk),
      .i_ibus_ack  (i_ibus_ack),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_cnt_en    (cnt_en),
      .o_alu_op    (alu_op),
      .o_op_b_imm  (op_b_imm),
      .o_rd_src    (rd_src),
      .o_rd_wen    (rd_wen),
      .o_rs1_adr   (rs1_adr),
      .o_rs2_adr   (rs2_adr),
      .o_rd_adr    (rd_adr),
      .o_mem_op    (mem_op),
      .o_is_load   (is_load),
      .o_is_store  (is_store),
      .o_branch    (branch),
      .o_branch_ne (branch_ne),
      .o_jal       (jal),
      .o_imm_bit   (imm_bit)
   );

   serial_regfile regfile (
      .clk       (clk),
      .i_cnt     (cnt),
      .i_wen     (rf_wen),
      .i_rs1_adr (rs1_adr),
      .i_rs2_adr (rs2_adr),
      .i_rd_adr  (rd_adr),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_first    (first),
      .i_op       (alu_op),
      .i_rs1_bit  (rs1_bit),
      .i_op_b_bit (op_b_bit),
      .o_rd_bit   (alu_bit),
      .o_eq       (alu_eq)
   );

   // PC arithmetic only runs in EXEC
   pc_ctrl ctrl (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_cnt_en      (exec),
      .i_first       (first),
      .i_pc_en       (pc_en),
      .i_imm_bit     (imm_bit),
      .i_take_target (take_target),
      .o_pc          (o_ibus_adr),
      .o_link_bit    (link_bit)
   );

   mem_bufreg bufreg (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_exec     (exec),
      .i_sum_bit  (alu_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_load_bit (load_bit)
   );

endmodule

// File: hdl/serial_regfile.sv
module serial_regfile import rv_isa_pkg::*; import core_cfg_pkg::*; (
   input  logic              clk,
   input  logic [CNT_W-1:0]  i_cnt,
   input  logic              i_wen,
   input  logic [REG_AW-1:0] i_rs1_adr,
   input  logic [REG_AW-1:0] i_rs2_adr,
   input  logic [REG_AW-1:0] i_rd_adr,
   input  logic              i_rd_bit,
   output logic              o_rs1_bit,
   output logic              o_rs2_bit
);

   logic [XLEN-1:0] regs [NREGS];
   logic [XLEN-1:0] rs1_word;
   logic [XLEN-1:0] rs2_word;

   // x0 reads as zero whatever the array holds
   assign rs1_word  = (i_rs1_adr == '0) ? '0 : regs[i_rs1_adr];
   assign rs2_word  = (i_rs2_adr == '0) ? '0 : regs[i_rs2_adr];
   assign o_rs1_bit = rs1_word[i_cnt];
   assign o_rs2_bit = rs2_word[i_cnt];

   // Bit i is read before it is overwritten, so rd may equal rs1 or rs2
   always_ff @(posedge clk) begin
      if (i_wen && i_rd_adr != '0) begin
         regs[i_rd_adr][i_cnt] <= i_rd_bit;
      end
   end

endmodule

// File: src.f
hdl/rv_isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/core_state.sv
hdl/instr_decode.sv
hdl/serial_regfile.sv
hdl/serial_alu.sv
hdl/pc_ctrl.sv
hdl/mem_bufreg.sv
hdl/serial_core_top.sv
tests/core_chk.sv
tests/core_tb.sv

// File: tests/core_chk.sv
module core_chk import rv_isa_pkg::*; import core_cfg_pkg::*; (
   input logic            clk,
   input logic            i_rst,
   input logic            i_ibus_cyc,
   input logic [XLEN-1:0] i_ibus_adr,
   input logic            i_ibus_ack,
   input logic            i_dbus_cyc,
   input logic [XLEN-1:0] i_dbus_adr,
   input logic [XLEN-1:0] i_dbus_dat,
   input logic            i_dbus_we,
   input logic            i_dbus_ack,
   input logic            i_mem_op,
   input logic [XLEN-1:0] i_exp_adr,
   input logic [XLEN-1:0] i_exp_dat
);

   int err_cnt = 0;

   // Both buses idle in the cycle reset falls
   a_reset_quiet: assert property (@(posedge clk)
      $fell(i_rst) |-> !i_ibus_cyc && !i_dbus_cyc)
      else begin
         $error("A bus cycle was requested in the cycle reset was released");
         err_cnt++;
      end

   a_first_fetch: assert property (@(posedge clk)
      $fell(i_rst) |=> i_ibus_cyc && i_ibus_adr == RESET_PC)
      else begin
         $error("CHECK FAILED o_ibus_adr: got %h (cyc %h), expected %h",
                $sampled(i_ibus_adr), $sampled(i_ibus_cyc), RESET_PC);
         err_cnt++;
      end

   a_ibus_hold: assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else begin
         $error("Fetch request dropped or moved before its ack, adr now %h",
                $sampled(i_ibus_adr));
         err_cnt++;
      end

   a_ibus_end: assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_cyc && i_ibus_ack |=> !i_ibus_cyc)
      else begin
         $error("Fetch request still high in the cycle after its ack");
         err_cnt++;
      end

   a_dbus_hold: assert property (@(posedge clk) disable iff (i_rst)
      i_dbus_cyc && !i_dbus_ack |=>
         i_dbus_cyc && $stable({i_dbus_adr, i_dbus_dat, i_dbus_we}))
      else begin
         $error("Data request dropped or changed before its ack, adr %h dat %h",
                $sampled(i_dbus_adr), $sampled(i_dbus_dat));
         err_cnt++;
      end

   a_dbus_end: assert property (@(posedge clk) disable iff (i_rst)
      i_dbus_cyc && i_dbus_ack |=> !i_dbus_cyc)
      else begin
         $error("Data request still high in the cycle after its ack");
         err_cnt++;
      end

   a_dbus_mem: assert property (@(posedge clk) disable iff (i_rst)
      i_dbus_cyc |-> i_mem_op)
      else begin
         $error("Data bus cycle without a load or store instruction");
         err_cnt++;
      end

   a_store_adr: assert property (@(posedge clk) disable iff (i_rst)
      i_dbus_cyc && i_dbus_we && i_dbus_ack |-> i_dbus_adr == i_exp_adr)
      else begin
         $error("CHECK FAILED o_dbus_adr: got %h, expected %h",
                $sampled(i_dbus_adr), $sampled(i_exp_adr));
         err_cnt++;
      end

   a_store_dat: assert property (@(posedge clk) disable iff (i_rst)
      i_dbus_cyc && i_dbus_we && i_dbus_ack |-> i_dbus_dat == i_exp_dat)
      else begin
         $error("CHECK FAILED o_dbus_dat: got %h, expected %h",
                $sampled(i_dbus_dat), $sampled(i_exp_dat));
         err_cnt++;
      end

   // 32 EXEC bits, then the next fetch
   a_fetch_gap: assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_cyc && i_ibus_ack ##1 !i_mem_op |-> !i_ibus_cyc [*32] ##1 i_ibus_cyc)
      else begin
         $error("Next fetch did not start 33 cycles after the ibus ack");
         err_cnt++;
      end

endmodule

// File: tests/core_tb.sv
module core_tb import rv_isa_pkg::*; import core_cfg_pkg::*; ();

   localparam int          CLK_PER = 8;
   localparam int          TDRV    = 1;
   localparam int          PROG_W  = 64;
   localparam logic [31:0] NOP     = 32'h0000_0013;
   localparam logic [12:0] BR_OFF  = 13'd8;
   localparam logic [20:0] JAL_OFF = 21'd8;

   logic            clk = 1'b0;
   logic            i_rst;
   logic [XLEN-1:0] i_ibus_rdt;
   logic            i_ibus_ack;
   logic [XLEN-1:0] i_dbus_rdt;
   logic            i_dbus_ack;
   logic [XLEN-1:0] o_ibus_adr;
   logic            o_ibus_cyc;
   logic [XLEN-1:0] o_dbus_adr;
   logic [XLEN-1:0] o_dbus_dat;
   logic            o_dbus_we;
   logic            o_dbus_cyc;

   logic [31:0] prog [PROG_W];
   logic [31:0] xr [32];
   logic [63:0] exp_q [$];
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic [31:0] asm_pc = RESET_PC;
   int          delays [256];
   int          dly_idx = 0;
   int          n_instr = 0;

   always #(CLK_PER / 2) clk = ~clk;

   serial_core_top UUT (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc)
   );

   bind serial_core_top core_chk chk (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_cyc (o_dbus_cyc),
      .i_dbus_adr (o_dbus_adr),
      .i_dbus_dat (o_dbus_dat),
      .i_dbus_we  (o_dbus_we),
      .i_dbus_ack (i_dbus_ack),
      .i_mem_op   (mem_op),
      .i_exp_adr  (core_tb.exp_adr),
      .i_exp_dat  (core_tb.exp_dat)
   );

   function automatic logic [31:0] sign_ext(input logic [31:0] imm);
      return {{20{imm[11]}}, imm[11:0]};
   endfunction

   // Preloaded data word, a hash of the whole address
   function automatic logic [31:0] mem_pattern(input logic [31:0] adr);
      return (adr * 32'h9e37_79b1) ^ {adr[15:0], adr[31:16]};
   endfunction

   function automatic logic [31:0] isa_result(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
      case (f3)
         FUNCT3_XOR: return a ^ b;
         FUNCT3_OR:  return a | b;
         FUNCT3_AND: return a & b;
         default:    return sub ? a - b : a + b;
      endcase
   endfunction

   function automatic logic [31:0] itype(input opcode_e opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [31:0] imm);
      return {imm[11:0], rs1, f3, rd, opc};
   endfunction

   function automatic int next_delay();
      int d;
      d = delays[dly_idx % 256];
      dly_idx++;
      return d;
   endfunction

   task automatic emit(input logic [31:0] word);
      prog[asm_pc[7:2]] = word;
      asm_pc += 4;
      n_instr++;
   endtask

   task automatic put_reg(input logic [4:0] rd, input logic [31:0] val);
      if (rd != '0) begin
         xr[rd] = val;
      end
   endtask

   task automatic load_upper(input logic [4:0] rd, input logic [31:0] imm);
      emit({imm[19:0], rd, OPC_LUI});
      put_reg(rd, {imm[19:0], 12'b0});
   endtask

   task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [31:0] imm);
      emit(itype(OPC_OP_IMM, f3, rd, rs1, imm));
      put_reg(rd, isa_result(f3, 1'b0, xr[rs1], sign_ext(imm)));
   endtask

   task automatic alu_reg(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
      emit({1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP});
      put_reg(rd, isa_result(f3, sub, xr[rs1], xr[rs2]));
   endtask

   task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
      emit(itype(OPC_LOAD, 3'b010, rd, rs1, imm));
      put_reg(rd, mem_pattern(xr[rs1] + sign_ext(imm)));
   endtask

   task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1, input logic [31:0] imm);
      emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
      exp_q.push_back({xr[rs1] + sign_ext(imm), xr[rs2]});
   endtask

   // Slot after a branch or jump, executed only on the fall-through path
   task automatic filler_slot(input logic skip);
      emit(itype(OPC_OP_IMM, FUNCT3_ADD, 5'd31, 5'd31, 32'd1));
      if (!skip) begin
         put_reg(5'd31, xr[31] + 1);
      end
   endtask

   task automatic cond_branch(input logic ne, input logic [4:0] rs1, input logic [4:0] rs2);
      logic taken;
      taken = (xr[rs1] == xr[rs2]) ^ ne;
      emit({BR_OFF[12], BR_OFF[10:5], rs2, rs1, (ne ? FUNCT3_BNE : FUNCT3_BEQ),
            BR_OFF[4:1], BR_OFF[11], OPC_BRANCH});
      filler_slot(taken);
   endtask

   task automatic jump_link(input logic [4:0] rd);
      logic [31:0] link;
      link = asm_pc + 4;
      emit({JAL_OFF[20], JAL_OFF[10:1], JAL_OFF[11], JAL_OFF[19:12], rd, OPC_JAL});
      put_reg(rd, link);
      filler_slot(1'b1);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #TDRV;
      end
   endtask

   task automatic show_head();
      if (exp_q.size() > 0) begin
         exp_adr = exp_q[0][63:32];
         exp_dat = exp_q[0][31:0];
      end else begin
         exp_adr = 'x;
         exp_dat = 'x;
      end
   endtask

   initial begin
      void'($urandom(32'hf082_03e8));
      i_rst      = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      foreach (delays[k]) delays[k] = $urandom_range(3);
      foreach (prog[k]) prog[k] = NOP;
      xr[0] = '0;
      load_upper(5'd1, $urandom());
      alu_imm(FUNCT3_ADD, 5'd1, 5'd1, $urandom());
      alu_imm(FUNCT3_XOR, 5'd3, 5'd1, $urandom());
      alu_imm(FUNCT3_OR, 5'd4, 5'd3, $urandom());
      alu_imm(FUNCT3_AND, 5'd5, 5'd4, $urandom());
      // Data base 0x1000
      load_upper(5'd2, 32'h1);
      alu_reg(FUNCT3_ADD, 1'b0, 5'd6, 5'd1, 5'd3);
      alu_reg(FUNCT3_ADD, 1'b1, 5'd7, 5'd1, 5'd4);
      alu_reg(FUNCT3_AND, 1'b0, 5'd8, 5'd3, 5'd5);
      alu_reg(FUNCT3_OR, 1'b0, 5'd9, 5'd4, 5'd7);
      alu_reg(FUNCT3_XOR, 1'b0, 5'd10, 5'd6, 5'd7);
      alu_imm(FUNCT3_ADD, 5'd0, 5'd1, $urandom());
      alu_reg(FUNCT3_ADD, 1'b1, 5'd11, 5'd0, 5'd1);
      for (int i = 0; i < 12; i++) begin
         store_word(5'(i), 5'd2, $urandom_range(255) * 4);
      end
      load_word(5'd12, 5'd2, $urandom_range(511) * 4);
      alu_imm(FUNCT3_ADD, 5'd13, 5'd12, $urandom());
      store_word(5'd13, 5'd2, $urandom_range(255) * 4);
      load_word(5'd14, 5'd2, $urandom_range(255) * 4 - 1024);
      store_word(5'd14, 5'd2, $urandom_range(255) * 4);
      load_upper(5'd31, $urandom());
      cond_branch(1'b0, 5'd1, 5'd1);
      cond_branch(1'b1, 5'd1, 5'd1);
      cond_branch(1'b0, 5'd1, 5'd3);
      cond_branch(1'b1, 5'd1, 5'd3);
      store_word(5'd31, 5'd2, $urandom_range(255) * 4);
      jump_link(5'd15);
      store_word(5'd15, 5'd2, $urandom_range(255) * 4);
      store_word(5'd31, 5'd2, $urandom_range(255) * 4);
      show_head();
      repeat (3) @(posedge clk);
      #TDRV;
      i_rst = 1'b0;
      wait (exp_q.size() == 0);
      repeat (4) @(posedge clk);
      if (UUT.chk.err_cnt == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Simulation FAILED");
         $fatal(1, "Assertion failures were counted by the checker");
      end
   end

   // Instruction bus responder
   initial begin
      forever begin
         @(posedge clk);
         #TDRV;
         if (o_ibus_cyc === 1'b1) begin
            wait_cycles(next_delay());
            i_ibus_rdt = (o_ibus_adr < 4 * PROG_W) ? prog[o_ibus_adr[7:2]] : NOP;
            i_ibus_ack = 1'b1;
            @(posedge clk);
            #TDRV;
            i_ibus_ack = 1'b0;
         end
      end
   end

   // Data bus responder, stores only retire the queue head
   initial begin
      logic is_wr;
      forever begin
         @(posedge clk);
         #TDRV;
         if (o_dbus_cyc === 1'b1) begin
            wait_cycles(next_delay());
            is_wr      = o_dbus_we;
            i_dbus_rdt = mem_pattern(o_dbus_adr);
            i_dbus_ack = 1'b1;
            @(posedge clk);
            #TDRV;
            i_dbus_ack = 1'b0;
            if (is_wr) begin
               void'(exp_q.pop_front());
               show_head();
            end
         end
      end
   end

   initial begin
      wait (UUT.chk.err_cnt != 0);
      $display("Simulation FAILED");
      $fatal(1, "An assertion in the bound checker failed");
   end

   initial begin
      wait (i_rst === 1'b0);
      #(n_instr * (33 + 32 + 2 * 4 + 4) * CLK_PER);
      $display("Simulation FAILED");
      $fatal(1, "Timeout: the program did not finish in the expected time");
   end

endmodule
